//--- Makefile
# Verilator build and run of the high-score restore testbench
TOP := tb_hiscore

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f compile.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- compile.f
hiscore_pkg.sv
hs_dpram.sv
hs_host_loader.sv
hs_restore_fsm.sv
hiscore_top.sv
hiscore_assert.sv
tb_clock.sv
tb_hiscore.sv

//--- hiscore_assert.sv
// ------------------------------
// Bound checker for hiscore_top
// Idle, pause, request and data rules
// Expected dump rebuilt from xorshift
// ------------------------------

`timescale 1ns/1ps

module hiscore_assert #(
	parameter int HS_ADDRESSWIDTH = 10,
	parameter int HS_DUMPINDEX    = 4
)(
	input logic                       clk,
	input logic                       rst_n,
	input logic                       paused,
	input logic                       data_ready,
	input hiscore_pkg::hs_ioctl_t     ioctl,
	input hiscore_pkg::byte_t         data_from_ram,
	input logic [HS_ADDRESSWIDTH-1:0] ram_address,
	input hiscore_pkg::byte_t         data_to_ram,
	input hiscore_pkg::byte_t         data_to_hps,
	input logic                       ram_read,
	input logic                       ram_write,
	input logic                       pause_cpu,
	input logic                       configured
);

	// Entry layout of the downloaded config
	localparam int          E0_BASE  = 'h040;
	localparam int          E0_LEN   = 5;
	localparam int          E1_BASE  = 'h100;
	localparam int          E1_LEN   = 4;
	localparam int          E0_START = 'hA5;
	localparam logic [31:0] SEED     = 32'h317d458a;

	logic       ready_q, pause_q, start_ok;   // start_ok: good start value seen
	logic       up_on_q1, up_on_q2;           // Upload pipeline, two stages
	logic [7:0] up_addr_q1, up_addr_q2;
	int         pause_falls, writes_done;
	int         error_count = 0;              // Read by the testbench top
	logic       ready_rise, upload_on;

	assign ready_rise = data_ready && !ready_q;
	assign upload_on  = ioctl.upload && (ioctl.index == 8'(HS_DUMPINDEX));

	// Dump byte k is output k+1 of the generator, low 8 bits
	function automatic hiscore_pkg::byte_t dump_byte(input int k);
		logic [31:0] x;
		x = SEED;
		for (int i = 0; i <= k; i++)
		begin
			x = x ^ (x << 13);
			x = x ^ (x >> 17);
			x = x ^ (x << 5);
		end
		return x[7:0];
	endfunction

	// Dump offset of a game address, -1 outside both entries
	function automatic int dump_offset(input int a);
		if (a >= E0_BASE && a < E0_BASE + E0_LEN)
			return a - E0_BASE;
		if (a >= E1_BASE && a < E1_BASE + E1_LEN)
			return E0_LEN + a - E1_BASE;
		return -1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ready_q <= 1'b0;
			pause_q <= 1'b0;
			start_ok <= 1'b0;
			up_on_q1 <= 1'b0;
			up_on_q2 <= 1'b0;
			up_addr_q1 <= 8'd0;
			up_addr_q2 <= 8'd0;
			pause_falls <= 0;
			writes_done <= 0;
		end
		else
		begin
			ready_q <= data_ready;
			pause_q <= pause_cpu;
			up_on_q1 <= upload_on;
			up_on_q2 <= up_on_q1;
			up_addr_q1 <= ioctl.addr[7:0];
			up_addr_q2 <= up_addr_q1;
			if (ram_read && ready_rise && int'(ram_address) == E0_BASE &&
				int'(data_from_ram) == E0_START)
				start_ok <= 1'b1;
			if (ram_write && ready_rise)
				writes_done <= writes_done + 1;   // Completed write accesses
			if (pause_q && !pause_cpu)
				pause_falls <= pause_falls + 1;
		end
	end

	// ------------------------------
	// Assertions
	// ------------------------------
	idle_before_config: assert property (@(posedge clk) disable iff (!rst_n)
		!configured |-> !pause_cpu && !ram_read && !ram_write)
		else begin $error("Game side activity before configuration"); error_count <= error_count + 1; end

	no_early_write: assert property (@(posedge clk) disable iff (!rst_n)
		ram_write |-> start_ok)
		else begin $error("Write before a good start value was read"); error_count <= error_count + 1; end

	first_check_clean: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(pause_cpu) && pause_falls == 0 |-> writes_done == 0)
		else begin $error("Writes during the failed first check"); error_count <= error_count + 1; end

	restore_count: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(pause_cpu) && pause_falls == 1 |-> writes_done == E0_LEN + E1_LEN)
		else begin
			$error("Mismatch write_count: expected %0d actual %0d", E0_LEN + E1_LEN, writes_done);
			error_count <= error_count + 1;
		end

	write_window: assert property (@(posedge clk) disable iff (!rst_n)
		ram_write |-> pause_cpu && paused && dump_offset(int'(ram_address)) >= 0)
		else begin $error("Write outside pause or outside an entry"); error_count <= error_count + 1; end

	write_data: assert property (@(posedge clk) disable iff (!rst_n)
		ram_write && dump_offset(int'(ram_address)) >= 0 |->
		data_to_ram == dump_byte(dump_offset(int'(ram_address))))
		else begin
			$error("Mismatch write_data: expected %h actual %h",
				dump_byte(dump_offset(int'(ram_address))), data_to_ram);
			error_count <= error_count + 1;
		end

	single_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(ram_read && ram_write))
		else begin $error("Read and write requested together"); error_count <= error_count + 1; end

	// Request held until the cycle that sees data_ready rise
	read_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$past(ram_read && !ready_rise) |-> ram_read)
		else begin $error("Read dropped before data_ready"); error_count <= error_count + 1; end

	write_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$past(ram_write && !ready_rise) |-> ram_write)
		else begin $error("Write dropped before data_ready"); error_count <= error_count + 1; end

	upload_data: assert property (@(posedge clk) disable iff (!rst_n)
		up_on_q2 |-> data_to_hps == dump_byte(int'(up_addr_q2)))
		else begin
			$error("Mismatch upload_read: expected %h actual %h",
				dump_byte(int'(up_addr_q2)), data_to_hps);
			error_count <= error_count + 1;
		end

endmodule

bind hiscore_top hiscore_assert #(
	.HS_ADDRESSWIDTH(HS_ADDRESSWIDTH), .HS_DUMPINDEX(HS_DUMPINDEX)
) chk0 (
	.clk(clk), .rst_n(rst_n), .paused(paused), .data_ready(data_ready),
	.ioctl(ioctl), .data_from_ram(data_from_ram), .ram_address(ram_address),
	.data_to_ram(data_to_ram), .data_to_hps(data_to_hps),
	.ram_read(ram_read), .ram_write(ram_write), .pause_cpu(pause_cpu),
	.configured(configured)
);

//--- hiscore_pkg.sv
// ------------------------------
// Shared types for the high-score restore logic
// Host port, entry, timing and status structs
// Config header offsets and restore FSM states
// ------------------------------

package hiscore_pkg;

	typedef logic [7:0]  byte_t;          // One data byte
	typedef logic [24:0] ioctl_addr_t;    // Host transfer byte address
	typedef logic [23:0] entry_addr_t;    // Game address field of a config entry

	// Host ioctl port as seen by the module
	typedef struct packed {
		logic        download;             // Host download in progress
		logic        upload;               // Host upload in progress
		logic        wr;                   // Download byte strobe
		logic [7:0]  index;                // Transfer index
		ioctl_addr_t addr;
		byte_t       dout;                 // Byte from host
	} hs_ioctl_t;

	// One config table entry
	typedef struct packed {
		entry_addr_t base;                 // First game RAM byte
		byte_t       length;               // Bytes in entry
		byte_t       start_val;            // Expected value at first byte
		byte_t       end_val;              // Expected value at last byte
	} hs_entry_t;

	// Frame counts from the config header
	typedef struct packed {
		logic [31:0] start_wait;
		logic [15:0] check_wait;
		logic [7:0]  pause_pad;
	} hs_timing_t;

	typedef struct packed {
		logic config_valid;                // Config download finished
		logic dump_valid;                  // Dump download finished
		logic uploading;                   // Host reading the dump back
	} hs_status_t;

	// Header layout, offsets point at the last byte of each field
	localparam ioctl_addr_t HDR_LENGTH          = 25'd16;
	localparam logic [3:0]  HDR_START_WAIT_LAST = 4'd3;
	localparam logic [3:0]  HDR_CHECK_WAIT_LAST = 4'd5;
	localparam logic [3:0]  HDR_PAUSE_PAD       = 4'd14;

	typedef enum logic [4:0] {
		IDLE, TIMER, WAIT_PAUSE, WAIT_DATA, INIT,
		CHECK_PREP, CHECK_BEGIN, CHECK_READY, CHECK_START, CHECK_END, CHECK_CANCEL,
		WRITE_BEGIN, WRITE_READY, WRITE_DONE, WRITE_COMPLETE, STOPPED
	} hs_state_e;

endpackage

//--- hiscore_top.sv
// ------------------------------
// High-score restore top level
// Host loader, dump store, restore FSM
// ------------------------------

`timescale 1ns/1ps

module hiscore_top #(
	parameter int HS_ADDRESSWIDTH  = 10,
	parameter int HS_SCOREWIDTH    = 8,
	parameter int CFG_ADDRESSWIDTH = 4,
	parameter int HS_CONFIGINDEX   = 3,
	parameter int HS_DUMPINDEX     = 4
)(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       core_reset,
	input  logic                       paused,
	input  logic                       v_sync,
	input  logic                       data_ready,
	input  hiscore_pkg::hs_ioctl_t     ioctl,
	input  hiscore_pkg::byte_t         data_from_ram,
	output logic [HS_ADDRESSWIDTH-1:0] ram_address,
	output hiscore_pkg::byte_t         data_to_ram,
	output hiscore_pkg::byte_t         data_to_hps,
	output logic                       ram_read,
	output logic                       ram_write,
	output logic                       pause_cpu,
	output logic                       configured
);

	hiscore_pkg::hs_entry_t      entry;
	hiscore_pkg::hs_timing_t     timing;
	hiscore_pkg::hs_status_t     status;
	logic [CFG_ADDRESSWIDTH-1:0] entry_index, last_entry;
	logic                        dump_we;
	logic [HS_SCOREWIDTH-1:0]    dump_addr, dump_rd_addr;
	hiscore_pkg::byte_t          dump_data, dump_q;

	assign configured  = status.config_valid;
	assign data_to_ram = dump_q;            // Same port serves restore and upload
	assign data_to_hps = dump_q;

	hs_host_loader #(
		.CFG_ADDRESSWIDTH(CFG_ADDRESSWIDTH), .HS_SCOREWIDTH(HS_SCOREWIDTH),
		.HS_CONFIGINDEX(HS_CONFIGINDEX), .HS_DUMPINDEX(HS_DUMPINDEX)
	) loader0 (
		.clk(clk), .rst_n(rst_n), .ioctl(ioctl),
		.entry_index(entry_index), .entry(entry), .last_entry(last_entry),
		.timing(timing), .status(status),
		.dump_we(dump_we), .dump_addr(dump_addr), .dump_data(dump_data)
	);

	// Dump store, host writes on A, restore and upload read on B
	hs_dpram #(.DATA_WIDTH(8), .ADDR_WIDTH(HS_SCOREWIDTH)) dump_store (
		.clk(clk),
		.addr_a(dump_addr), .d_a(dump_data), .we_a(dump_we), .q_a(),
		.addr_b(dump_rd_addr), .d_b(8'd0), .we_b(1'b0), .q_b(dump_q)
	);

	hs_restore_fsm #(
		.HS_ADDRESSWIDTH(HS_ADDRESSWIDTH), .HS_SCOREWIDTH(HS_SCOREWIDTH),
		.CFG_ADDRESSWIDTH(CFG_ADDRESSWIDTH)
	) restore0 (
		.clk(clk), .rst_n(rst_n), .core_reset(core_reset), .paused(paused),
		.v_sync(v_sync), .data_ready(data_ready), .ioctl_addr(ioctl.addr),
		.status(status), .timing(timing), .entry(entry), .last_entry(last_entry),
		.data_from_ram(data_from_ram), .entry_index(entry_index),
		.dump_rd_addr(dump_rd_addr), .ram_address(ram_address),
		.ram_read(ram_read), .ram_write(ram_write), .pause_cpu(pause_cpu)
	);

endmodule

//--- hs_dpram.sv
// ------------------------------
// Dual-port RAM with registered reads
// ------------------------------

`timescale 1ns/1ps

module hs_dpram #(
	parameter int DATA_WIDTH = 8,
	parameter int ADDR_WIDTH = 8
)(
	input  logic                  clk,
	input  logic [ADDR_WIDTH-1:0] addr_a,
	input  logic [DATA_WIDTH-1:0] d_a,
	input  logic                  we_a,
	output logic [DATA_WIDTH-1:0] q_a,
	input  logic [ADDR_WIDTH-1:0] addr_b,
	input  logic [DATA_WIDTH-1:0] d_b,
	input  logic                  we_b,
	output logic [DATA_WIDTH-1:0] q_b
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

	// Both ports in one block, write data passes through to q
	always_ff @(posedge clk)
	begin
		if (we_a)
		begin
			mem[addr_a] <= d_a;
			q_a <= d_a;
		end
		else
			q_a <= mem[addr_a];

		if (we_b)
		begin
			mem[addr_b] <= d_b;
			q_b <= d_b;
		end
		else
			q_b <= mem[addr_b];
	end

endmodule

//--- hs_host_loader.sv
// ------------------------------
// Host download decode
// Header fields, entry tables, dump store writes
// Loaded and uploading flags
// ------------------------------

`timescale 1ns/1ps

module hs_host_loader #(
	parameter int CFG_ADDRESSWIDTH = 4,
	parameter int HS_SCOREWIDTH    = 8,
	parameter int HS_CONFIGINDEX   = 3,
	parameter int HS_DUMPINDEX     = 4
)(
	input  logic                        clk,
	input  logic                        rst_n,
	input  hiscore_pkg::hs_ioctl_t      ioctl,
	input  logic [CFG_ADDRESSWIDTH-1:0] entry_index,
	output hiscore_pkg::hs_entry_t      entry,
	output logic [CFG_ADDRESSWIDTH-1:0] last_entry,
	output hiscore_pkg::hs_timing_t     timing,
	output hiscore_pkg::hs_status_t     status,
	output logic                        dump_we,
	output logic [HS_SCOREWIDTH-1:0]    dump_addr,
	output hiscore_pkg::byte_t          dump_data
);

	logic                        cfg_dl;          // Config transfer active
	logic                        dump_dl;         // Dump transfer active
	logic                        hdr_byte;        // Config byte falls in header
	logic                        ent_byte;        // Config byte falls in entry area
	logic [3:0]                  hdr_off;
	logic [2:0]                  ent_off;         // Byte offset inside an 8-byte entry
	logic [CFG_ADDRESSWIDTH-1:0] cfg_slot;        // Entry number of current byte
	hiscore_pkg::byte_t          last1, last2, last3;
	logic                        last_download;
	logic [7:0]                  last_index;

	hiscore_pkg::entry_addr_t    base_q;
	hiscore_pkg::byte_t          length_q, start_q, end_q;

	assign cfg_dl   = ioctl.download && (ioctl.index == 8'(HS_CONFIGINDEX));
	assign dump_dl  = ioctl.download && (ioctl.index == 8'(HS_DUMPINDEX));
	assign hdr_byte = cfg_dl && ioctl.wr && (ioctl.addr < hiscore_pkg::HDR_LENGTH);
	assign ent_byte = cfg_dl && ioctl.wr && !(ioctl.addr < hiscore_pkg::HDR_LENGTH);
	assign hdr_off  = ioctl.addr[3:0];
	assign ent_off  = ioctl.addr[2:0];
	assign cfg_slot = ioctl.addr[CFG_ADDRESSWIDTH+2:3] - CFG_ADDRESSWIDTH'(2); // Skip header

	// Dump bytes go straight into the store
	assign dump_we   = dump_dl && ioctl.wr;
	assign dump_addr = ioctl.addr[HS_SCOREWIDTH-1:0];
	assign dump_data = ioctl.dout;

	assign status.uploading = ioctl.upload && (ioctl.index == 8'(HS_DUMPINDEX));

	// ------------------------------
	// Byte cascade and header fields
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (ioctl.download && ioctl.wr)
		begin
			last3 <= last2;
			last2 <= last1;
			last1 <= ioctl.dout;
		end
		if (hdr_byte)
		begin
			if (hdr_off == hiscore_pkg::HDR_START_WAIT_LAST)
				timing.start_wait <= {last3, last2, last1, ioctl.dout};
			if (hdr_off == hiscore_pkg::HDR_CHECK_WAIT_LAST)
				timing.check_wait <= {last1, ioctl.dout};
			if (hdr_off == hiscore_pkg::HDR_PAUSE_PAD)
				timing.pause_pad <= ioctl.dout;
		end
	end

	// Valid flags latch when a download ends
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			status.config_valid <= 1'b0;
			status.dump_valid <= 1'b0;
			last_download <= 1'b0;
			last_index <= 8'd0;
			last_entry <= '0;
		end
		else
		begin
			last_download <= ioctl.download;
			last_index <= ioctl.index;
			if (ent_byte)
				last_entry <= cfg_slot;            // Highest slot seen so far
			if (last_download && !ioctl.download)
			begin
				if (last_index == 8'(HS_CONFIGINDEX))
					status.config_valid <= 1'b1;
				if (last_index == 8'(HS_DUMPINDEX))
					status.dump_valid <= 1'b1;
			end
		end
	end

	// ------------------------------
	// Entry tables
	// ------------------------------
	hs_dpram #(.DATA_WIDTH(24), .ADDR_WIDTH(CFG_ADDRESSWIDTH)) base_table (
		.clk(clk),
		.addr_a(cfg_slot), .d_a({last2, last1, ioctl.dout}),
		.we_a(ent_byte && (ent_off == 3'd3)), .q_a(),
		.addr_b(entry_index), .d_b(24'd0), .we_b(1'b0), .q_b(base_q)
	);

	hs_dpram #(.DATA_WIDTH(8), .ADDR_WIDTH(CFG_ADDRESSWIDTH)) length_table (
		.clk(clk),
		.addr_a(cfg_slot), .d_a(ioctl.dout),
		.we_a(ent_byte && (ent_off == 3'd4)), .q_a(),
		.addr_b(entry_index), .d_b(8'd0), .we_b(1'b0), .q_b(length_q)
	);

	hs_dpram #(.DATA_WIDTH(8), .ADDR_WIDTH(CFG_ADDRESSWIDTH)) start_table (
		.clk(clk),
		.addr_a(cfg_slot), .d_a(ioctl.dout),
		.we_a(ent_byte && (ent_off == 3'd5)), .q_a(),
		.addr_b(entry_index), .d_b(8'd0), .we_b(1'b0), .q_b(start_q)
	);

	hs_dpram #(.DATA_WIDTH(8), .ADDR_WIDTH(CFG_ADDRESSWIDTH)) end_table (
		.clk(clk),
		.addr_a(cfg_slot), .d_a(ioctl.dout),
		.we_a(ent_byte && (ent_off == 3'd6)), .q_a(),
		.addr_b(entry_index), .d_b(8'd0), .we_b(1'b0), .q_b(end_q)
	);

	assign entry = {base_q, length_q, start_q, end_q};

endmodule

//--- hs_restore_fsm.sv
// ------------------------------
// Restore FSM with frame timer
// Game RAM requests, dump store addressing
// ------------------------------

`timescale 1ns/1ps

module hs_restore_fsm #(
	parameter int HS_ADDRESSWIDTH  = 10,
	parameter int HS_SCOREWIDTH    = 8,
	parameter int CFG_ADDRESSWIDTH = 4
)(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        core_reset,
	input  logic                        paused,         // Core confirms CPU halt
	input  logic                        v_sync,
	input  logic                        data_ready,     // Game side access strobe
	input  hiscore_pkg::ioctl_addr_t    ioctl_addr,
	input  hiscore_pkg::hs_status_t     status,
	input  hiscore_pkg::hs_timing_t     timing,
	input  hiscore_pkg::hs_entry_t      entry,
	input  logic [CFG_ADDRESSWIDTH-1:0] last_entry,
	input  hiscore_pkg::byte_t          data_from_ram,
	output logic [CFG_ADDRESSWIDTH-1:0] entry_index,
	output logic [HS_SCOREWIDTH-1:0]    dump_rd_addr,
	output logic [HS_ADDRESSWIDTH-1:0]  ram_address,
	output logic                        ram_read,
	output logic                        ram_write,
	output logic                        pause_cpu
);

	hiscore_pkg::hs_state_e      state, ret_state;  // Return state for wait states
	logic [31:0]                 wait_timer;         // Frames left in TIMER
	logic                        vsync_last, ready_last, reset_last;
	logic [CFG_ADDRESSWIDTH-1:0] entry_index_q;      // Entry under check or write
	logic [HS_SCOREWIDTH-1:0]    data_addr;          // Dump store read pointer
	logic [HS_SCOREWIDTH-1:0]    base_io_addr;       // First dump byte of current entry
	logic [HS_SCOREWIDTH-1:0]    entry_offset;
	hiscore_pkg::entry_addr_t    ram_addr;
	hiscore_pkg::entry_addr_t    end_addr;
	hiscore_pkg::byte_t          rd_data;            // Byte taken on data_ready
	logic                        frame_tick, ready_rise, restore_go;

	assign frame_tick   = v_sync && !vsync_last;
	assign ready_rise   = data_ready && !ready_last;
	assign restore_go   = reset_last && !core_reset && status.config_valid && status.dump_valid;
	assign entry_offset = data_addr - base_io_addr;
	assign end_addr     = entry.base + hiscore_pkg::entry_addr_t'(entry.length) - 24'd1;

	assign entry_index  = entry_index_q;
	assign dump_rd_addr = data_addr;
	assign ram_address  = ram_addr[HS_ADDRESSWIDTH-1:0];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= hiscore_pkg::IDLE;
			ret_state <= hiscore_pkg::IDLE;
			wait_timer <= 32'd0;
			vsync_last <= 1'b0;
			ready_last <= 1'b0;
			reset_last <= 1'b0;
			entry_index_q <= '0;
			data_addr <= '0;
			base_io_addr <= '0;
			ram_addr <= '0;
			rd_data <= 8'd0;
			ram_read <= 1'b0;
			ram_write <= 1'b0;
			pause_cpu <= 1'b0;
		end
		else
		begin
			vsync_last <= v_sync;
			ready_last <= data_ready;
			reset_last <= core_reset;
			if (status.uploading)
				data_addr <= ioctl_addr[HS_SCOREWIDTH-1:0];   // Upload reads follow host

			if (restore_go)
			begin
				wait_timer <= timing.start_wait;
				ret_state <= hiscore_pkg::INIT;
				state <= hiscore_pkg::TIMER;
				ram_read <= 1'b0;
				ram_write <= 1'b0;
				pause_cpu <= 1'b0;
			end
			else if (!status.uploading || state == hiscore_pkg::WAIT_DATA)
			begin
				case (state)
					hiscore_pkg::IDLE: ;             // Wait for end of core reset
					hiscore_pkg::TIMER:
					begin
						if (wait_timer == 32'd0)
							state <= ret_state;
						else if (frame_tick)
							wait_timer <= wait_timer - 32'd1;
					end
					hiscore_pkg::WAIT_PAUSE:
					begin
						if (paused)
						begin
							wait_timer <= {24'd0, timing.pause_pad};  // Settle before access
							state <= hiscore_pkg::TIMER;
						end
					end
					hiscore_pkg::WAIT_DATA:
					begin
						if (ready_rise)
						begin
							ram_read <= 1'b0;
							ram_write <= 1'b0;
							rd_data <= data_from_ram;
							state <= ret_state;
						end
					end
					hiscore_pkg::INIT:
					begin
						entry_index_q <= '0;
						data_addr <= '0;
						base_io_addr <= '0;
						state <= hiscore_pkg::CHECK_PREP;
					end

					// ------------------------------
					// Start and end value checks
					// ------------------------------
					hiscore_pkg::CHECK_PREP:
					begin
						pause_cpu <= 1'b1;
						ret_state <= hiscore_pkg::CHECK_BEGIN;
						state <= hiscore_pkg::WAIT_PAUSE;
					end
					hiscore_pkg::CHECK_BEGIN:
						state <= hiscore_pkg::CHECK_READY;   // Entry table read latency
					hiscore_pkg::CHECK_READY:
					begin
						ram_addr <= entry.base;
						ram_read <= 1'b1;
						ret_state <= hiscore_pkg::CHECK_START;
						state <= hiscore_pkg::WAIT_DATA;
					end
					hiscore_pkg::CHECK_START:
					begin
						if (rd_data == entry.start_val)
						begin
							ram_addr <= end_addr;
							ram_read <= 1'b1;
							ret_state <= hiscore_pkg::CHECK_END;
							state <= hiscore_pkg::WAIT_DATA;
						end
						else
						begin
							wait_timer <= {24'd0, timing.pause_pad};
							ret_state <= hiscore_pkg::CHECK_CANCEL;
							state <= hiscore_pkg::TIMER;
						end
					end
					hiscore_pkg::CHECK_END:
					begin
						if (rd_data != entry.end_val)
						begin
							wait_timer <= {24'd0, timing.pause_pad};
							ret_state <= hiscore_pkg::CHECK_CANCEL;
							state <= hiscore_pkg::TIMER;
						end
						else if (entry_index_q == last_entry)
						begin
							entry_index_q <= '0;          // All entries good, go write
							state <= hiscore_pkg::WRITE_BEGIN;
						end
						else
						begin
							entry_index_q <= entry_index_q + 1'b1;
							state <= hiscore_pkg::CHECK_BEGIN;
						end
					end
					hiscore_pkg::CHECK_CANCEL:
					begin
						pause_cpu <= 1'b0;                // Let the game run, retry later
						wait_timer <= {16'd0, timing.check_wait};
						ret_state <= hiscore_pkg::INIT;
						state <= hiscore_pkg::TIMER;
					end

					// ------------------------------
					// Dump write to game RAM
					// ------------------------------
					hiscore_pkg::WRITE_BEGIN:
						state <= hiscore_pkg::WRITE_READY;
					hiscore_pkg::WRITE_READY:
					begin
						ram_addr <= entry.base + hiscore_pkg::entry_addr_t'(entry_offset);
						ram_write <= 1'b1;
						ret_state <= hiscore_pkg::WRITE_DONE;
						state <= hiscore_pkg::WAIT_DATA;
					end
					hiscore_pkg::WRITE_DONE:
					begin
						data_addr <= data_addr + 1'b1;
						if (ram_addr != end_addr)
							state <= hiscore_pkg::WRITE_READY;
						else if (entry_index_q == last_entry)
							state <= hiscore_pkg::WRITE_COMPLETE;
						else
						begin
							entry_index_q <= entry_index_q + 1'b1;
							base_io_addr <= data_addr + 1'b1;  // Next entry starts here
							state <= hiscore_pkg::WRITE_BEGIN;
						end
					end
					hiscore_pkg::WRITE_COMPLETE:
					begin
						wait_timer <= {24'd0, timing.pause_pad};
						ret_state <= hiscore_pkg::STOPPED;
						state <= hiscore_pkg::TIMER;
					end
					hiscore_pkg::STOPPED:
						pause_cpu <= 1'b0;                // Restore done
					default:
						state <= hiscore_pkg::IDLE;
				endcase
			end
		end
	end

endmodule

//--- tb_clock.sv
// ------------------------------
// Testbench clock and reset generator
// ------------------------------

`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD       = 10,    // ns
	parameter int RESET_CYCLES = 5
)(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Release on a falling edge, same as the stimulus
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- tb_hiscore.sv
// ------------------------------
// Testbench top for hiscore_top
// Host stimulus, game RAM model, xorshift
// ------------------------------

`timescale 1ns/1ps

module tb_hiscore;

	localparam int TIMEOUT    = 20000;   // Cycles per wait
	localparam int SIG_RESET  = 0;
	localparam int SIG_CONFIG = 1;
	localparam int SIG_PAUSE  = 2;

	logic                       clk, rst_n;
	logic                       core_reset;
	logic                       paused = 1'b0;
	logic                       v_sync = 1'b0;
	logic                       data_ready = 1'b0;
	hiscore_pkg::hs_ioctl_t     ioctl;
	hiscore_pkg::byte_t         data_from_ram = 8'd0;
	logic [9:0]                 ram_address;
	hiscore_pkg::byte_t         data_to_ram, data_to_hps;
	logic                       ram_read, ram_write, pause_cpu, configured;

	hiscore_pkg::byte_t         game_ram [1024];
	hiscore_pkg::byte_t         xfer [32];      // Bytes of the next download
	logic [2:0]                 pause_hist = 3'd0;
	int                         req_age = 0;    // Cycles the current request is old
	int                         frame_cnt = 0;
	logic [31:0]                rng;

	tb_clock #(.PERIOD(10), .RESET_CYCLES(5)) clk0 (.clk(clk), .rst_n(rst_n));

	hiscore_top #(
		.HS_ADDRESSWIDTH(10), .HS_SCOREWIDTH(8), .CFG_ADDRESSWIDTH(4),
		.HS_CONFIGINDEX(3), .HS_DUMPINDEX(4)
	) dut0 (
		.clk(clk), .rst_n(rst_n), .core_reset(core_reset), .paused(paused),
		.v_sync(v_sync), .data_ready(data_ready), .ioctl(ioctl),
		.data_from_ram(data_from_ram), .ram_address(ram_address),
		.data_to_ram(data_to_ram), .data_to_hps(data_to_hps), .ram_read(ram_read),
		.ram_write(ram_write), .pause_cpu(pause_cpu), .configured(configured)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_run(input string reason);
		$display("Error: %s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped after an error");
	endtask

	// Poll one DUT output on falling edges until it reaches level
	task automatic wait_until(input int sel, input logic level, input string what);
		int   cycles;
		logic now;
		cycles = 0;
		now = ~level;
		while (now !== level)
		begin
			@(negedge clk);
			case (sel)
				SIG_RESET:  now = rst_n;
				SIG_CONFIG: now = configured;
				default:    now = pause_cpu;
			endcase
			cycles++;
			if (cycles > TIMEOUT)
				fail_run({"Timeout waiting for ", what});
		end
	endtask

	// One byte every other cycle, index held while download drops
	task automatic send_download(input logic [7:0] index, input int count);
		ioctl.index = index;
		ioctl.download = 1'b1;
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			ioctl.addr = 25'(i);
			ioctl.dout = xfer[i];
			ioctl.wr = 1'b1;
			@(negedge clk);
			ioctl.wr = 1'b0;
		end
		@(negedge clk);
		ioctl.download = 1'b0;
	endtask

	// Header plus two entries
	task automatic build_config;
		for (int i = 0; i < 32; i++)
			xfer[i] = 8'd0;
		xfer[3] = 8'd2;                        // start_wait
		xfer[5] = 8'd3;                        // check_wait
		xfer[14] = 8'd1;                       // pause_pad
		xfer[19] = 8'h40;                      // Entry 0 base 0x000040
		xfer[20] = 8'd5;
		xfer[21] = 8'hA5;
		xfer[22] = 8'h5A;
		xfer[26] = 8'h01;                      // Entry 1 base 0x000100
		xfer[28] = 8'd4;
		xfer[29] = 8'h3C;
		xfer[30] = 8'hC3;
	endtask

	// ------------------------------
	// Game side model
	// ------------------------------
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			pause_hist = 3'd0;
			paused = 1'b0;
			data_ready = 1'b0;
			req_age = 0;
			frame_cnt = 0;
			v_sync = 1'b0;
		end
		else
		begin
			pause_hist = {pause_hist[1:0], pause_cpu};
			paused = pause_hist[2];             // Three cycles behind pause_cpu
			frame_cnt = (frame_cnt == 39) ? 0 : frame_cnt + 1;
			v_sync = (frame_cnt == 0);
			if (data_ready)
			begin
				data_ready = 1'b0;              // Single-cycle strobe
				req_age = 0;
			end
			else if (ram_read || ram_write)
			begin
				req_age++;
				if (req_age == 2)
				begin
					if (ram_write)
						game_ram[ram_address] = data_to_ram;
					data_from_ram = game_ram[ram_address];
					data_ready = 1'b1;
				end
			end
		end
	end

	always @(negedge clk)
	begin
		if (dut0.chk0.error_count != 0)
			fail_run("An assertion of the bound checker failed");
	end

	initial
	begin
		core_reset = 1'b1;
		ioctl = '0;
		for (int a = 0; a < 1024; a++)
			game_ram[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5C;
		game_ram['h040] = 8'h5A;                // Wrong start value at first
		game_ram['h044] = 8'h5A;
		game_ram['h100] = 8'h3C;
		game_ram['h103] = 8'hC3;

		wait_until(SIG_RESET, 1'b1, "reset release");

		// Core leaves reset with nothing loaded, restore must stay idle
		core_reset = 1'b0;
		repeat (8) @(negedge clk);
		core_reset = 1'b1;

		build_config();
		send_download(8'd3, 32);
		wait_until(SIG_CONFIG, 1'b1, "configured");

		rng = 32'h317d458a;
		for (int k = 0; k < 9; k++)
		begin
			rng = xorshift32(rng);
			xfer[k] = rng[7:0];
		end
		send_download(8'd4, 9);
		repeat (4) @(negedge clk);              // dump_valid settles
		core_reset = 1'b0;

		wait_until(SIG_PAUSE, 1'b1, "first pause");
		wait_until(SIG_PAUSE, 1'b0, "end of first check");
		game_ram['h040] = 8'hA5;
		wait_until(SIG_PAUSE, 1'b1, "second pause");
		wait_until(SIG_PAUSE, 1'b0, "end of restore");
		repeat (4) @(negedge clk);

		// Read the dump back
		ioctl.index = 8'd4;
		ioctl.upload = 1'b1;
		for (int k = 0; k < 9; k++)
		begin
			ioctl.addr = 25'(k);
			@(negedge clk);
		end
		ioctl.upload = 1'b0;
		repeat (4) @(negedge clk);

		if (dut0.chk0.error_count != 0)
			fail_run("Assertion failures at end of run");
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule
